//--- src/ranging_pkg.sv
package ranging_pkg;

    // Ping cycle, in clock cycles
    localparam int TRIG_WIDTH  = 5;
    localparam int TRIG_PERIOD = 200;

    // Echo shorter than this counts as near
    localparam int ECHO_THRESHOLD = 30;

    // Near echoes in a row before an obstacle is reported
    localparam int CONFIRM_COUNT = 3;

    localparam int RANGE_W = 16;    // Ping, echo and confirm counters

endpackage

//--- src/nav_pkg.sv
package nav_pkg;

    typedef enum logic [3:0] {
        STOP,
        FORWARD,
        SIDE_RIGHT,
        SIDE_LEFT,
        BACKWARD,
        REVERSE,
        TURN_RIGHT,
        TURN_LEFT,
        TURN_BACK
    } nav_state_t;

    // Motion opcode to the drive stage
    typedef enum logic [2:0] {
        HALT,
        AHEAD,
        ASTERN,
        SPIN_LEFT,
        SPIN_RIGHT
    } drive_cmd_t;

    localparam int TIMER_W = 16;

    // Maneuver lengths in cycles, short for simulation
    localparam int REVERSE_CYCLES = 60;
    localparam int TURN_CYCLES    = 40;
    localparam int AVOID_CYCLES   = 80;     // Each side leg
    localparam int SETTLE_CYCLES  = 4;      // Inputs ignored after a state change

    localparam int DIST_W = 32;             // Signed odometer

endpackage

//--- src/ultrasonic_ranger.sv
`timescale 1ns/1ps

module ultrasonic_ranger (
    input  logic clk,
    input  logic reset,
    input  logic echo,
    output logic trig,
    output logic obstacle
);
    import ranging_pkg::*;

    logic [RANGE_W-1:0] ping_cnt;
    logic [RANGE_W-1:0] echo_len;
    logic [RANGE_W-1:0] confirm_cnt;
    logic               armed;      // Trigger done, waiting for echo to end
    logic               near;

    assign near     = (echo_len < RANGE_W'(ECHO_THRESHOLD));
    assign obstacle = (confirm_cnt == RANGE_W'(CONFIRM_COUNT));

    // Free-running ping window
    always_ff @(posedge clk) begin
        if (reset) begin
            ping_cnt <= '0;
            trig     <= 1'b0;
        end else begin
            trig <= (ping_cnt < RANGE_W'(TRIG_WIDTH));
            if (ping_cnt == RANGE_W'(TRIG_PERIOD - 1))
                ping_cnt <= '0;
            else
                ping_cnt <= ping_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            armed       <= 1'b0;
            echo_len    <= '0;
            confirm_cnt <= '0;
        end else if (ping_cnt == RANGE_W'(TRIG_WIDTH)) begin
            armed    <= 1'b1;       // trig falls on this edge
            echo_len <= '0;
        end else if (armed) begin
            if (echo) begin
                if (echo_len != '1)
                    echo_len <= echo_len + 1'b1;
            end else if (echo_len != '0) begin
                // Falling edge of echo, judge the distance
                armed <= 1'b0;
                if (!near)
                    confirm_cnt <= '0;
                else if (!obstacle)
                    confirm_cnt <= confirm_cnt + 1'b1;
            end
        end
    end

endmodule

//--- src/maneuver_timer.sv
`timescale 1ns/1ps

module maneuver_timer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load,
    input  logic [nav_pkg::TIMER_W-1:0] length,
    output logic                        done
);
    import nav_pkg::*;

    logic [TIMER_W-1:0] count;

    assign done = (count == '0);

    // Loaded with length-1 so done rises length cycles after the load
    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (load)
            count <= (length == '0) ? '0 : length - 1'b1;
        else if (!done)
            count <= count - 1'b1;
    end

endmodule

//--- src/nav_fsm.sv
`timescale 1ns/1ps

module nav_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        obstacle,
    input  logic                        maneuver_done,
    output nav_pkg::drive_cmd_t         drive_cmd,
    output logic                        timer_load,
    output logic [nav_pkg::TIMER_W-1:0] timer_length
);
    import nav_pkg::*;

    nav_state_t         state;
    nav_state_t         next_state;
    nav_state_t         last_heading;
    logic [TIMER_W-1:0] settle_cnt;
    logic               settled;

    function automatic logic [TIMER_W-1:0] state_duration(input nav_state_t s);
        case (s)
            REVERSE:                          return TIMER_W'(REVERSE_CYCLES);
            TURN_RIGHT, TURN_LEFT, TURN_BACK: return TIMER_W'(TURN_CYCLES);
            SIDE_RIGHT, SIDE_LEFT, BACKWARD:  return TIMER_W'(AVOID_CYCLES);
            default:                          return '0;
        endcase
    endfunction

    function automatic logic is_heading(input nav_state_t s);
        return s inside {FORWARD, SIDE_RIGHT, SIDE_LEFT, BACKWARD};
    endfunction

    assign settled      = (settle_cnt == '0);
    assign timer_load   = (next_state != state);
    assign timer_length = state_duration(next_state);

    always_comb begin
        next_state = state;
        if (settled) begin
            case (state)
                STOP:
                    if (start)
                        next_state = FORWARD;
                FORWARD:
                    if (obstacle)
                        next_state = REVERSE;
                SIDE_RIGHT, SIDE_LEFT, BACKWARD:
                    if (obstacle)
                        next_state = REVERSE;
                    else if (maneuver_done)
                        next_state = TURN_LEFT;
                REVERSE:
                    if (maneuver_done)
                        next_state = TURN_RIGHT;
                TURN_RIGHT:
                    if (maneuver_done) begin
                        case (last_heading)
                            FORWARD:    next_state = SIDE_RIGHT;
                            SIDE_LEFT:  next_state = FORWARD;
                            SIDE_RIGHT: next_state = BACKWARD;
                            BACKWARD:   next_state = SIDE_LEFT;
                            default:    next_state = STOP;
                        endcase
                    end
                TURN_LEFT:
                    if (maneuver_done) begin
                        if (obstacle)
                            next_state = TURN_BACK;     // Left side blocked too
                        else begin
                            case (last_heading)
                                SIDE_RIGHT: next_state = FORWARD;
                                SIDE_LEFT:  next_state = BACKWARD;
                                BACKWARD:   next_state = SIDE_RIGHT;
                                default:    next_state = STOP;
                            endcase
                        end
                    end
                TURN_BACK:
                    if (maneuver_done)
                        next_state = last_heading;
                default:
                    next_state = STOP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= STOP;
            last_heading <= STOP;
            settle_cnt   <= '0;
        end else begin
            state <= next_state;
            if (timer_load) begin
                settle_cnt <= TIMER_W'(SETTLE_CYCLES);
                if (is_heading(next_state))
                    last_heading <= next_state;
            end else if (!settled) begin
                settle_cnt <= settle_cnt - 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            FORWARD, SIDE_RIGHT, SIDE_LEFT, BACKWARD: drive_cmd = AHEAD;
            REVERSE:                                  drive_cmd = ASTERN;
            TURN_LEFT:                                drive_cmd = SPIN_LEFT;
            TURN_RIGHT, TURN_BACK:                    drive_cmd = SPIN_RIGHT;
            default:                                  drive_cmd = HALT;
        endcase
    end

endmodule

//--- src/drive_stage.sv
`timescale 1ns/1ps

module drive_stage (
    input  logic                               clk,
    input  logic                               reset,
    input  nav_pkg::drive_cmd_t                drive_cmd,
    output logic                               left_s1,
    output logic                               left_s2,
    output logic                               left_s3,
    output logic                               left_s4,
    output logic                               right_s1,
    output logic                               right_s2,
    output logic                               right_s3,
    output logic                               right_s4,
    output logic signed [nav_pkg::DIST_W-1:0] distance
);
    import nav_pkg::*;

    logic       left_active, left_reverse;
    logic       right_active, right_reverse;
    logic [3:0] left_coil, right_coil;      // s1 in the top bit

    function automatic logic [3:0] coil_pattern(input logic active, input logic reverse);
        if (!active)
            return 4'b0000;
        if (reverse)
            return 4'b0110;
        return 4'b1001;
    endfunction

    always_comb begin
        left_active   = (drive_cmd != HALT);
        right_active  = (drive_cmd != HALT);
        left_reverse  = (drive_cmd == ASTERN) || (drive_cmd == SPIN_LEFT);
        right_reverse = (drive_cmd == ASTERN) || (drive_cmd == SPIN_RIGHT);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            left_coil  <= 4'b0000;
            right_coil <= 4'b0000;
            distance   <= '0;
        end else begin
            left_coil  <= coil_pattern(left_active, left_reverse);
            right_coil <= coil_pattern(right_active, right_reverse);
            if (drive_cmd == AHEAD)
                distance <= distance + 1'b1;
            else if (drive_cmd == ASTERN)
                distance <= distance - 1'b1;
        end
    end

    assign {left_s1, left_s2, left_s3, left_s4}     = left_coil;
    assign {right_s1, right_s2, right_s3, right_s4} = right_coil;

endmodule

//--- src/robot_top.sv
`timescale 1ns/1ps

module robot_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  logic                               echo,
    output logic                               trig,
    output logic                               left_s1,
    output logic                               left_s2,
    output logic                               left_s3,
    output logic                               left_s4,
    output logic                               right_s1,
    output logic                               right_s2,
    output logic                               right_s3,
    output logic                               right_s4,
    output logic signed [nav_pkg::DIST_W-1:0] distance
);
    import nav_pkg::*;

    logic               obstacle;
    drive_cmd_t         drive_cmd;
    logic               timer_load;
    logic [TIMER_W-1:0] timer_length;
    logic               maneuver_done;

    ultrasonic_ranger ranger (
        .clk      (clk),
        .reset    (reset),
        .echo     (echo),
        .trig     (trig),
        .obstacle (obstacle)
    );

    nav_fsm fsm (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .obstacle      (obstacle),
        .maneuver_done (maneuver_done),
        .drive_cmd     (drive_cmd),
        .timer_load    (timer_load),
        .timer_length  (timer_length)
    );

    maneuver_timer timer (
        .clk    (clk),
        .reset  (reset),
        .load   (timer_load),
        .length (timer_length),
        .done   (maneuver_done)
    );

    drive_stage drive (
        .clk       (clk),
        .reset     (reset),
        .drive_cmd (drive_cmd),
        .left_s1   (left_s1),
        .left_s2   (left_s2),
        .left_s3   (left_s3),
        .left_s4   (left_s4),
        .right_s1  (right_s1),
        .right_s2  (right_s2),
        .right_s3  (right_s3),
        .right_s4  (right_s4),
        .distance  (distance)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);
    localparam time HALF_PERIOD = 10ns;     // 20 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- bench/robot_tb.sv
`timescale 1ns/1ps

module robot_tb;
    import ranging_pkg::*;
    import nav_pkg::*;

    localparam int TIMEOUT_CYCLES = 8000;
    localparam int TURN_WAIT      = 1000;   // Bound for the whole avoidance run

    // Motion seen on the coil lines
    localparam logic [2:0] M_IDLE = 0, M_FWD = 1, M_REV = 2, M_SPIN_R = 3, M_SPIN_L = 4;
    localparam logic [2:0] M_OTHER = 5;

    logic clk, reset, start, echo, trig;
    logic left_s1, left_s2, left_s3, left_s4;
    logic right_s1, right_s2, right_s3, right_s4;
    logic signed [DIST_W-1:0] distance;
    logic [3:0] left_coil, right_coil;
    logic [2:0] motion_now, cur_motion;
    int seg_len, trig_high, since_rise, trig_rises, coil_fails;
    int fail_count, tests_passed, tests_failed, cycles, fails_before, rev_wait, fwd_wait;
    logic seen_rise, idle_check, no_reverse, seq_active, trig_last, near_now;
    logic [15:0] lfsr;
    logic echo_plan[$];     // 1 for a near echo
    int echo_len;

    tb_clock clock_gen (.clk(clk), .reset(reset));

    robot_top dut (
        .clk(clk), .reset(reset), .start(start), .echo(echo), .trig(trig),
        .left_s1(left_s1), .left_s2(left_s2), .left_s3(left_s3), .left_s4(left_s4),
        .right_s1(right_s1), .right_s2(right_s2), .right_s3(right_s3), .right_s4(right_s4),
        .distance(distance)
    );

    assign left_coil  = {left_s1, left_s2, left_s3, left_s4};
    assign right_coil = {right_s1, right_s2, right_s3, right_s4};
    assign motion_now = motion_of(left_coil, right_coil);

    function automatic logic [2:0] motion_of(input logic [3:0] l, input logic [3:0] r);
        if (l == 4'b0000 && r == 4'b0000) return M_IDLE;
        if (l == 4'b1001 && r == 4'b1001) return M_FWD;
        if (l == 4'b0110 && r == 4'b0110) return M_REV;
        if (l == 4'b1001 && r == 4'b0110) return M_SPIN_R;
        if (l == 4'b0110 && r == 4'b1001) return M_SPIN_L;
        return M_OTHER;
    endfunction

    function automatic logic coil_legal(input logic [3:0] c);
        return c == 4'b0000 || c == 4'b1001 || c == 4'b0110;
    endfunction

    function automatic int odo_step(input logic [2:0] m);
        if (m == M_FWD) return 1;
        if (m == M_REV) return -1;
        return 0;
    endfunction

    // Allowed segment changes during avoidance, with minimum lengths
    function automatic logic step_legal(input logic [2:0] cur, input logic [2:0] nxt,
                                        input int len);
        case (cur)
            M_REV:    return nxt == M_SPIN_R && len >= REVERSE_CYCLES;
            M_SPIN_R: return nxt == M_FWD && len >= TURN_CYCLES;
            // Leg cut short while the obstacle is still confirmed
            M_FWD:    return (nxt == M_SPIN_L && len >= AVOID_CYCLES) ||
                             (nxt == M_REV && len >= SETTLE_CYCLES);
            default:  return 1'b0;
        endcase
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic note_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        fail_count++;
    endtask

    task automatic report_test(input string name);
        if (fail_count == fails_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, fail_count - fails_before);
        end
        fails_before = fail_count;
    endtask

    task automatic run_echoes(input logic a, input logic b, input logic c);
        echo_plan.push_back(a);
        echo_plan.push_back(b);
        echo_plan.push_back(c);
        while (echo_plan.size() != 0 || echo)
            @(negedge clk);
    endtask

    // Monitors sampled on the rising edge
    always @(posedge clk) begin
        if (reset) begin
            trig_high <= 0;
            since_rise <= 0;
            seen_rise <= 1'b0;
            trig_rises <= 0;
            cur_motion <= M_IDLE;
            seg_len <= 0;
        end else begin
            trig_high <= trig ? trig_high + 1 : 0;
            if (trig && since_rise != 0 && trig_high == 0) begin
                since_rise <= 1;
                seen_rise <= 1'b1;
                trig_rises <= trig_rises + 1;
            end else if (trig && !seen_rise && trig_high == 0) begin
                since_rise <= 1;
                trig_rises <= trig_rises + 1;
            end else if (since_rise != 0) begin
                since_rise <= since_rise + 1;
            end
            if (motion_now != cur_motion) begin
                cur_motion <= motion_now;
                seg_len <= 1;
            end else begin
                seg_len <= seg_len + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        coil_legal(left_coil) && coil_legal(right_coil))
        else begin
            note_fail("coil lines form no valid pattern");
            coil_fails++;
        end
    assert property (@(posedge clk) disable iff (reset)
        idle_check |-> (left_coil == 4'b0000 && right_coil == 4'b0000 && distance == 0))
        else note_fail("motors or distance not idle before start");
    assert property (@(posedge clk) disable iff (reset)
        $fell(trig) |-> trig_high == TRIG_WIDTH)
        else note_fail("trig pulse width wrong");
    assert property (@(posedge clk) disable iff (reset)
        $rose(trig) && seen_rise |-> since_rise == TRIG_PERIOD)
        else note_fail("trig period wrong");
    assert property (@(posedge clk) disable iff (reset)
        distance - $past(distance) == odo_step(motion_now))
        else note_fail("odometer step does not match motion");
    assert property (@(posedge clk) disable iff (reset)
        no_reverse |-> motion_now != M_REV)
        else note_fail("reverse without a confirmed obstacle");
    assert property (@(posedge clk) disable iff (reset)
        seq_active && motion_now != cur_motion |-> step_legal(cur_motion, motion_now, seg_len))
        else note_fail("avoidance segment out of order or too short");

    // Echo model, one pulse per trig fall
    initial begin
        trig_last = 1'b0;
        forever begin
            @(negedge clk);
            if (trig_last && !trig) begin
                // Far unless a test queued near echoes
                near_now = (echo_plan.size() != 0) ? echo_plan.pop_front() : 1'b0;
                if (near_now) begin
                    take_bits(4, echo_len);
                    echo_len = echo_len + 5;     // 5 to 20
                end else begin
                    take_bits(5, echo_len);
                    echo_len = echo_len + 40;    // 40 to 71
                end
                echo = 1'b1;
                repeat (echo_len) @(negedge clk);
                echo = 1'b0;
            end
            trig_last = trig;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        start = 1'b0;
        echo = 1'b0;
        lfsr = 16'd33365;
        idle_check = 1'b0;
        no_reverse = 1'b0;
        seq_active = 1'b0;
        fail_count = 0;
        coil_fails = 0;
        fails_before = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles = 0;
        @(negedge clk);
        while (reset)
            @(negedge clk);

        idle_check = 1'b1;
        repeat (500) @(negedge clk);
        idle_check = 1'b0;
        report_test("idle after reset");

        fails_before = fail_count;
        begin : trig_test
            int rises_at;
            rises_at = trig_rises;
            while (trig_rises < rises_at + 3)
                @(negedge clk);
        end
        report_test("trig timing");

        start = 1'b1;
        fwd_wait = 0;
        while (motion_now != M_FWD && fwd_wait <= SETTLE_CYCLES + 2) begin
            @(negedge clk);
            fwd_wait++;
        end
        assert (fwd_wait <= SETTLE_CYCLES + 2)
            else note_fail("forward pattern late after start");
        repeat (100) @(negedge clk);
        report_test("start forward");

        no_reverse = 1'b1;
        run_echoes(1'b1, 1'b1, 1'b0);
        repeat (10) @(negedge clk);
        no_reverse = 1'b0;
        run_echoes(1'b1, 1'b1, 1'b1);
        rev_wait = 0;
        while (motion_now != M_REV && rev_wait <= TRIG_PERIOD) begin
            @(negedge clk);
            rev_wait++;
        end
        assert (rev_wait <= TRIG_PERIOD)
            else note_fail("no reverse after confirmed obstacle");
        seq_active = 1'b1;
        repeat (20) @(negedge clk);
        report_test("obstacle confirmation");

        rev_wait = 0;
        while (motion_now != M_SPIN_L && rev_wait < TURN_WAIT) begin
            @(negedge clk);
            rev_wait++;
        end
        // One more edge so the step into the left turn is checked
        @(negedge clk);
        seq_active = 1'b0;
        if (rev_wait >= TURN_WAIT) begin
            $display("Avoidance sequence never reached the left turn");
            fail_count++;
        end
        report_test("avoidance sequence");

        fails_before = fail_count - coil_fails;     // Coil errors of the whole run
        report_test("coil patterns");
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
src/ranging_pkg.sv
src/nav_pkg.sv
src/ultrasonic_ranger.sv
src/maneuver_timer.sv
src/nav_fsm.sv
src/drive_stage.sv
src/robot_top.sv
bench/tb_clock.sv
bench/robot_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f tb.f --top-module robot_tb -o robot_sim
./obj_dir/robot_sim > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
